/* hdl/sprite_pkg.sv */
// Shared types, 640x480 display timing and sprite placement tables.
// Every design file imports this package inside its body.
package sprite_pkg;

    localparam int CORDW = 10;
    typedef logic [CORDW-1:0] coord_t;  // screen coordinate

    // horizontal timing in pixels
    localparam coord_t H_RES   = 10'd640;
    localparam coord_t H_FP    = 10'd16;
    localparam coord_t H_SYNC  = 10'd96;
    localparam coord_t H_BP    = 10'd48;
    localparam coord_t H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam coord_t HS_STA  = H_RES + H_FP;                   // 656
    localparam coord_t HS_END  = HS_STA + H_SYNC - 10'd1;        // 751

    // vertical timing in lines
    localparam coord_t V_RES   = 10'd480;
    localparam coord_t V_FP    = 10'd10;
    localparam coord_t V_SYNC  = 10'd2;
    localparam coord_t V_BP    = 10'd33;
    localparam coord_t V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525
    localparam coord_t VS_STA  = V_RES + V_FP;
    localparam coord_t VS_END  = VS_STA + V_SYNC - 10'd1;

    // glyph geometry
    localparam int GLYPH_W     = 8;
    localparam int GLYPH_H     = 8;
    localparam int GLYPH_COUNT = 8;
    localparam int SCALE       = 4;  // same factor in x and y
    localparam int ROM_ADDRW   = $clog2(GLYPH_COUNT * GLYPH_H);
    localparam GLYPH_FILE      = "glyphs_8x8.mem";

    typedef logic [GLYPH_W-1:0]         glyph_row_t;   // msb is the leftmost pixel
    typedef logic [ROM_ADDRW-1:0]       rom_addr_t;    // glyph * 8 + row
    typedef logic [$clog2(GLYPH_W)-1:0] glyph_col_t;
    typedef logic [$clog2(GLYPH_H)-1:0] glyph_line_t;
    typedef logic [$clog2(SCALE)-1:0]   scale_t;

    localparam coord_t BOX_W = coord_t'(GLYPH_W * SCALE);  // drawn width

    // sprite placement
    localparam int     NUM_SPRITES = 5;
    localparam coord_t SPR_Y       = 10'd208;  // first drawn line
    localparam coord_t SPR_X_TABLE [NUM_SPRITES] = '{10'd158, 10'd222, 10'd286, 10'd350, 10'd414};
    localparam int     SPR_GLYPH_TABLE [NUM_SPRITES] = '{3, 0, 5, 1, 6};

    localparam int SLOT_LEN = 2;  // rom cycles per engine
    localparam int PIPE_LAT = 2;  // output delay behind video

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        coord_t sx;
        coord_t sy;
    } video_t;

    localparam video_t VIDEO_IDLE = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, sx: '0, sy: '0};

    typedef enum logic [2:0] {
        IDLE, WAIT_SLOT, LOAD, WAIT_LINE, DRAW, LINE_END, DONE
    } spr_state_t;

endpackage

/* hdl/display_timings.sv */
// 640x480 timing generator. Counts pixel clocks into screen coordinates and
// registers sync and data enable alongside them as one aligned video word.
`timescale 1ns/1ps

module display_timings (
    input  logic               clk_pix,
    input  logic               rst_n,
    output sprite_pkg::video_t video
);
    import sprite_pkg::*;

    coord_t cnt_x;  // horizontal position
    coord_t cnt_y;  // vertical position
    logic   last_x;
    logic   last_y;

    always_comb begin
        last_x = (cnt_x == H_TOTAL - 10'd1);
        last_y = (cnt_y == V_TOTAL - 10'd1);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            cnt_x <= '0;
            cnt_y <= '0;
        end else begin
            cnt_x <= last_x ? '0 : cnt_x + 10'd1;
            if (last_x) begin
                cnt_y <= last_y ? '0 : cnt_y + 10'd1;
            end
        end
    end

    // flags are compared from the counters and registered with them
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            video <= VIDEO_IDLE;  // blank with both syncs idle
        end else begin
            video.sx    <= cnt_x;
            video.sy    <= cnt_y;
            video.hsync <= !(cnt_x >= HS_STA && cnt_x <= HS_END);  // active low
            video.vsync <= !(cnt_y >= VS_STA && cnt_y <= VS_END);  // active low
            video.de    <= (cnt_x < H_RES) && (cnt_y < V_RES);
        end
    end

endmodule

/* hdl/glyph_rom.sv */
// Glyph ROM, eight 8x8 glyphs loaded from the hex mem file.
// Single read port whose data follows the address by one clock.
`timescale 1ns/1ps

module glyph_rom (
    input  logic                   clk_pix,
    input  sprite_pkg::rom_addr_t  addr,
    output sprite_pkg::glyph_row_t data
);
    import sprite_pkg::*;

    glyph_row_t mem [GLYPH_COUNT*GLYPH_H];

    initial begin
        $readmemh(GLYPH_FILE, mem);
    end

    always_ff @(posedge clk_pix) begin
        data <= mem[addr];  // block ram style read
    end

endmodule

/* hdl/sprite_fetch.sv */
// Shares the glyph ROM among the sprite engines. Issues the frame start
// pulse and one fetch slot per engine in horizontal blanking, and muxes the
// engine addresses onto the ROM.
`timescale 1ns/1ps

module sprite_fetch (
    input  logic                                           clk_pix,
    input  logic                                           rst_n,
    input  sprite_pkg::video_t                             video,
    input  sprite_pkg::rom_addr_t [sprite_pkg::NUM_SPRITES-1:0] spr_addr,
    output logic                                           start,
    output logic [sprite_pkg::NUM_SPRITES-1:0]             slot,
    output sprite_pkg::rom_addr_t                          rom_addr
);
    import sprite_pkg::*;

    coord_t sx_next;  // position of the coming cycle
    logic   line_wrap;

    always_comb begin
        line_wrap = (video.sx == H_TOTAL - 10'd1);
        sx_next   = line_wrap ? '0 : video.sx + 10'd1;
    end

    // decoded one pixel ahead so the registered strobes match sx
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            start <= 1'b0;
            slot  <= '0;
        end else begin
            start <= line_wrap && (video.sy == SPR_Y - 10'd2);  // sy 207, sx 0
            for (int i = 0; i < NUM_SPRITES; i++) begin
                slot[i] <= (sx_next >= H_RES + coord_t'(SLOT_LEN * i))
                        && (sx_next <  H_RES + coord_t'(SLOT_LEN * (i + 1)));
            end
        end
    end

    always_comb begin
        rom_addr = '0;  // idle address outside the slots
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (slot[i]) begin
                rom_addr = spr_addr[i];
            end
        end
    end

endmodule

/* hdl/sprite.sv */
// Sprite engine. Fetches one glyph row per line in its ROM slot, then draws
// it enlarged by SCALE at its x position on the following line. IDX picks
// the glyph and the x position from the package tables.
`timescale 1ns/1ps

module sprite #(
    parameter int IDX = 0
) (
    input  logic                   clk_pix,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   slot_en,
    input  sprite_pkg::video_t     video,
    input  sprite_pkg::glyph_row_t rom_data,
    output sprite_pkg::rom_addr_t  rom_addr,
    output logic                   pix,
    output logic                   done
);
    import sprite_pkg::*;

    localparam coord_t    SPR_X      = SPR_X_TABLE[IDX];
    localparam rom_addr_t GLYPH_BASE = rom_addr_t'(SPR_GLYPH_TABLE[IDX] * GLYPH_H);
    localparam glyph_col_t  COL_MAX  = glyph_col_t'(GLYPH_W - 1);
    localparam glyph_line_t ROW_MAX  = glyph_line_t'(GLYPH_H - 1);
    localparam scale_t      SCL_MAX  = scale_t'(SCALE - 1);

    spr_state_t  state;
    glyph_line_t row;      // source row of the glyph
    scale_t      rep;      // repeats of the current row
    glyph_col_t  col;      // source column inside the box
    scale_t      scl;      // repeats of the current column
    glyph_row_t  row_buf;
    logic        in_box;

    always_comb begin
        in_box   = (video.sx >= SPR_X) && (video.sx < SPR_X + BOX_W);
        rom_addr = GLYPH_BASE + rom_addr_t'(row);
        pix      = (state == DRAW) && in_box && row_buf[COL_MAX - col];
        done     = (state == DONE);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
            row   <= '0;
            rep   <= '0;
        end else if (start) begin
            state <= WAIT_SLOT;  // restart from any state
            row   <= '0;
            rep   <= '0;
        end else begin
            case (state)
                WAIT_SLOT: begin
                    if (slot_en) begin
                        state <= LOAD;
                    end
                end
                LOAD: state <= WAIT_LINE;  // rom data valid now
                WAIT_LINE: begin
                    if (video.sx == H_TOTAL - 10'd1) begin
                        state <= DRAW;
                    end
                end
                DRAW: begin
                    if (video.sx == SPR_X + BOX_W - 10'd1) begin
                        state <= LINE_END;
                    end
                end
                LINE_END: begin
                    state <= WAIT_SLOT;
                    rep   <= rep + scale_t'(1);
                    if (rep == SCL_MAX) begin
                        row <= row + glyph_line_t'(1);
                        if (row == ROW_MAX) begin
                            state <= DONE;  // all 32 lines drawn
                        end
                    end
                end
                default: state <= state;  // IDLE and DONE wait for start
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (state == LOAD) begin
            row_buf <= rom_data;
        end
    end

    // column walk restarts whenever sx is outside the box
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            col <= '0;
            scl <= '0;
        end else if (state == DRAW && in_box) begin
            scl <= scl + scale_t'(1);
            if (scl == SCL_MAX) begin
                col <= col + glyph_col_t'(1);
            end
        end else begin
            col <= '0;
            scl <= '0;
        end
    end

endmodule

/* hdl/pixel_mixer.sv */
// Output stage. Merges the sprite pixels with the foreground and background
// colours, blanks outside the active area, and keeps sync aligned with rgb.
`timescale 1ns/1ps

module pixel_mixer (
    input  logic                              clk_pix,
    input  logic                              rst_n,
    input  sprite_pkg::video_t                video,
    input  logic [sprite_pkg::NUM_SPRITES-1:0] pix,
    input  sprite_pkg::rgb_t                  fg,
    input  sprite_pkg::rgb_t                  bg,
    output logic                              hsync,
    output logic                              vsync,
    output logic                              de,
    output sprite_pkg::rgb_t                  rgb
);
    import sprite_pkg::*;

    video_t ctl_d [PIPE_LAT-1];    // sync and enable delay line
    logic   spr_on_d [PIPE_LAT-1];

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int k = 0; k < PIPE_LAT - 1; k++) begin
                ctl_d[k]    <= VIDEO_IDLE;
                spr_on_d[k] <= 1'b0;
            end
            hsync <= 1'b1;
            vsync <= 1'b1;
            de    <= 1'b0;
            rgb   <= '0;
        end else begin
            ctl_d[0]    <= video;
            spr_on_d[0] <= |pix;  // any sprite wins over bg
            for (int k = 1; k < PIPE_LAT - 1; k++) begin
                ctl_d[k]    <= ctl_d[k-1];
                spr_on_d[k] <= spr_on_d[k-1];
            end
            hsync <= ctl_d[PIPE_LAT-2].hsync;
            vsync <= ctl_d[PIPE_LAT-2].vsync;
            de    <= ctl_d[PIPE_LAT-2].de;
            if (!ctl_d[PIPE_LAT-2].de) begin
                rgb <= '0;  // blanking
            end else begin
                rgb <= spr_on_d[PIPE_LAT-2] ? fg : bg;  // colours sampled here
            end
        end
    end

endmodule

/* hdl/hello_sprites.sv */
// Text sprite renderer for a 640x480 display on the pixel clock. Five
// engines draw scaled glyphs from a shared ROM over a runtime background.
`timescale 1ns/1ps

module hello_sprites (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  sprite_pkg::rgb_t fg,          // glyph colour
    input  sprite_pkg::rgb_t bg,          // background colour
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output sprite_pkg::rgb_t rgb,
    output logic             frame_done   // all sprites finished
);
    import sprite_pkg::*;

    video_t                       video;
    logic                         spr_start;
    logic [NUM_SPRITES-1:0]       slot;
    rom_addr_t [NUM_SPRITES-1:0]  spr_addr;
    rom_addr_t                    rom_addr;
    glyph_row_t                   rom_data;
    logic [NUM_SPRITES-1:0]       spr_pix;
    logic [NUM_SPRITES-1:0]       spr_done;

    display_timings timings (
        .clk_pix, .rst_n, .video
    );

    sprite_fetch fetch (
        .clk_pix, .rst_n, .video, .spr_addr,
        .start(spr_start), .slot, .rom_addr
    );

    glyph_rom rom (
        .clk_pix, .addr(rom_addr), .data(rom_data)
    );

    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_spr
        sprite #(.IDX(i)) spr (
            .clk_pix,
            .rst_n,
            .start    (spr_start),
            .slot_en  (slot[i]),
            .video,
            .rom_data,
            .rom_addr (spr_addr[i]),
            .pix      (spr_pix[i]),
            .done     (spr_done[i])
        );
    end

    pixel_mixer mixer (
        .clk_pix, .rst_n, .video, .pix(spr_pix),
        .fg, .bg, .hsync, .vsync, .de, .rgb
    );

    assign frame_done = &spr_done;

endmodule

/* tests/hello_sprites_assertions.sv */
// Concurrent checks on the output sync and blanking of the sprite renderer.
// Bound into the top level, so it sees the output ports directly.
`timescale 1ns/1ps

module hello_sprites_assertions (
    input logic             clk_pix,
    input logic             rst_n,
    input logic             hsync,
    input logic             de,
    input sprite_pkg::rgb_t rgb
);
    int low_len;  // cycles of the current hsync pulse

    always_ff @(posedge clk_pix) begin
        if (!rst_n || hsync) begin
            low_len <= 0;
        end else begin
            low_len <= low_len + 1;
        end
    end

    blank_rgb_zero: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !de |-> (rgb == 12'h000)) else $error("rgb not zero while blanked");

    no_de_in_hsync: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(de && !hsync)) else $error("de high during hsync pulse");

    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $rose(hsync) |-> (low_len == 96)) else $error("hsync pulse width wrong");

endmodule

bind hello_sprites hello_sprites_assertions sync_checks (.*);

/* tests/tb_hello_sprites.sv */
// Testbench for the sprite renderer. Random colours and one mid-frame reset
// drive it, and each output pixel is compared against a model built from the glyph file.
`timescale 1ns/1ps

module tb_hello_sprites;
    import sprite_pkg::*;

    localparam int     CLK_PERIOD  = 8;
    localparam int     FRAME_CYC   = 420000;
    localparam longint WATCHDOG_NS = 64'd5 * FRAME_CYC * CLK_PERIOD + 64'd1_000_000;

    logic clk_pix;
    logic rst_n;
    rgb_t fg;
    rgb_t bg;
    logic hsync;
    logic vsync;
    logic de;
    rgb_t rgb;
    logic frame_done;

    int         seed = 32'hfcb5_94a9;
    logic [7:0] font [64];  // copy of the glyph rows
    int         checks = 0;
    int         errs = 0;
    int         phase_checks = 0;
    int         phase_errs = 0;
    logic       started = 1'b0;
    logic       in_reset_q = 1'b1;
    int         post_cnt = 0;
    int         px;          // output pixel position
    int         py;
    logic       prev_de = 1'b0;
    logic       prev_hs = 1'b1;
    logic       prev_vs = 1'b1;
    logic       prev_done = 1'b0;
    longint     cyc = 0;
    longint     t_hfall;
    longint     t_vfall;
    longint     t_derise;
    logic       seen_hfall;
    logic       seen_vfall;
    logic       seen_derise;
    logic       done_seen;
    int         wait_cyc;
    int         rst_len;

    hello_sprites UUT (.*);

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog timeout, the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            $display("ERR %s: expected %0h, actual %0h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errs++;
        end
    endtask

    task automatic pick_colours();
        fg = rgb_t'($random(seed));
        bg = rgb_t'($random(seed));
        if (bg == fg) begin
            bg = ~fg;  // keep glyphs visible
        end
    endtask

    task automatic finish_phase(input string name);
        $display("test %s done: %0d checks, %0d errors", name,
                 checks - phase_checks, errs - phase_errs);
        phase_checks = checks;
        phase_errs   = errs;
    endtask

    task automatic reset_model();
        px          = 0;
        py          = 0;
        seen_hfall  = 1'b0;
        seen_vfall  = 1'b0;
        seen_derise = 1'b0;
        done_seen   = 1'b0;
    endtask

    // colour the model expects at output pixel (x, y)
    function automatic int expected_rgb(input int x, input int y);
        int   row;
        int   col;
        int   sx0;
        rgb_t res;
        res = bg;
        if (y >= int'(SPR_Y) && y < int'(SPR_Y) + 32) begin
            row = (y - int'(SPR_Y)) / 4;
            for (int i = 0; i < NUM_SPRITES; i++) begin
                sx0 = int'(SPR_X_TABLE[i]);
                if (x >= sx0 && x < sx0 + 32) begin
                    col = (x - sx0) / 4;
                    if (font[SPR_GLYPH_TABLE[i] * 8 + row][7 - col]) begin
                        res = fg;
                    end
                end
            end
        end
        return int'(res);
    endfunction

    always @(posedge clk_pix) begin
        in_reset_q <= !rst_n;
        started    <= 1'b1;
    end

    // outputs change on the rising edge, sampled here on the falling one
    always @(negedge clk_pix) begin
        if (started) begin
            cyc++;
            if (in_reset_q || post_cnt > 0) begin
                check_true(hsync && vsync && !de && rgb == 12'h000,
                           "outputs not idle during or right after reset");
                post_cnt = in_reset_q ? PIPE_LAT : post_cnt - 1;
                reset_model();
            end else begin
                if (de) begin
                    check_value("pixel", expected_rgb(px, py), int'(rgb));
                    px++;
                end else begin
                    check_value("blank", 0, int'(rgb));
                end
                if (prev_hs && !hsync) begin
                    if (seen_hfall) begin
                        check_value("line_period", 800, int'(cyc - t_hfall));
                    end
                    seen_hfall = 1'b1;
                    t_hfall    = cyc;
                end
                if (!prev_hs && hsync && seen_hfall) begin
                    check_value("hsync_low", 96, int'(cyc - t_hfall));
                end
                if (!prev_de && de) begin
                    seen_derise = 1'b1;
                    t_derise    = cyc;
                end
                if (prev_de && !de) begin
                    if (seen_derise) begin
                        check_value("de_length", 640, int'(cyc - t_derise));
                    end
                    py++;
                    px = 0;
                end
                if (prev_vs && !vsync) begin
                    if (seen_vfall) begin
                        check_value("frame_period", FRAME_CYC, int'(cyc - t_vfall));
                    end
                    check_true(done_seen, "frame_done did not rise during the frame");
                    seen_vfall = 1'b1;
                    t_vfall    = cyc;
                    done_seen  = 1'b0;
                    py         = 0;
                end
                if (!prev_vs && vsync && seen_vfall) begin
                    check_value("vsync_low", 1600, int'(cyc - t_vfall));
                end
                if (!prev_done && frame_done) begin
                    check_value("done_rise_line", int'(SPR_Y) + 31, py);
                    done_seen = 1'b1;
                end
                if (prev_done && !frame_done) begin
                    check_value("done_fall_line", int'(SPR_Y) - 1, py);
                end
            end
            prev_de   = de;
            prev_hs   = hsync;
            prev_vs   = vsync;
            prev_done = frame_done;
        end
    end

    // new colours once per vertical sync
    initial begin
        forever begin
            @(negedge vsync);
            @(posedge clk_pix);
            #1 pick_colours();
        end
    end

    initial begin
        rst_n = 1'b0;
        pick_colours();
        $readmemh("glyphs_8x8.mem", font);
        repeat (8) @(posedge clk_pix);
        #1 rst_n = 1'b1;
        repeat (2) @(negedge vsync);
        finish_phase("colour_frames");

        wait_cyc = int'($unsigned($random(seed)) % FRAME_CYC);
        rst_len  = 8 + int'($unsigned($random(seed)) % 33);
        repeat (wait_cyc) @(posedge clk_pix);
        #1 rst_n = 1'b0;
        repeat (rst_len) @(posedge clk_pix);
        #1 rst_n = 1'b1;
        repeat (4) @(posedge clk_pix);
        finish_phase("mid_frame_reset");

        repeat (2) @(negedge vsync);
        repeat (4) @(posedge clk_pix);
        finish_phase("recovery_frames");

        $display("total: %0d checks, %0d errors", checks, errs);
        if (errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* glyphs_8x8.mem */
// one glyph row per line as two hex digits, msb is the leftmost pixel
// glyph n occupies rows n*8 to n*8+7, glyphs 0..7 are H E L O W R D !
66
66
66
7E
66
66
66
00
7E
60
60
7C
60
60
7E
00
60
60
60
60
60
60
7E
00
3C
66
66
66
66
66
3C
00
63
63
63
6B
7F
77
63
00
7C
66
66
7C
78
6C
66
00
78
6C
66
66
66
6C
78
00
18
18
18
18
18
00
18
00

/* hello_sprites.f */
hdl/sprite_pkg.sv
hdl/display_timings.sv
hdl/glyph_rom.sv
hdl/sprite_fetch.sv
hdl/sprite.sv
hdl/pixel_mixer.sv
hdl/hello_sprites.sv
tests/hello_sprites_assertions.sv
tests/tb_hello_sprites.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f hello_sprites.f \
    --top-module tb_hello_sprites -o sim_hello_sprites

out=$(./obj_dir/sim_hello_sprites)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
